// ==== Bender.yml ====
package:
  name: rv64_core

sources:
  - design/core_pkg.sv
  - design/stage_link.sv
  - design/reg_read_if.sv
  - design/fetch_stage.sv
  - design/decode_stage.sv
  - design/reg_file.sv
  - design/execute_stage.sv
  - design/memory_stage.sv
  - design/core_top.sv
  - target: test
    files:
      - dv/core_model.sv
      - dv/core_tb.sv

// ==== design/core_pkg.sv ====
`default_nettype none

package core_pkg;

  typedef logic [63:0] xlen_t;
  typedef logic [31:0] inst_t;
  typedef logic [4:0]  reg_addr_t;
  typedef logic [2:0]  alu_op_t;

  localparam alu_op_t ALU_ADD = 3'd0;
  localparam alu_op_t ALU_SUB = 3'd1;
  localparam alu_op_t ALU_AND = 3'd2;
  localparam alu_op_t ALU_OR  = 3'd3;
  localparam alu_op_t ALU_XOR = 3'd4;

  // major opcodes of the supported subset
  localparam logic [6:0] OPC_OP_IMM = 7'h13;
  localparam logic [6:0] OPC_OP     = 7'h33;
  localparam logic [6:0] OPC_LOAD   = 7'h03;
  localparam logic [6:0] OPC_STORE  = 7'h23;
  localparam logic [6:0] OPC_BRANCH = 7'h63;
  localparam logic [6:0] OPC_PUTCH  = 7'h7b;

  // putch prints the low byte of a0
  localparam reg_addr_t REG_A0 = 5'd10;

  localparam xlen_t RESET_PC = 64'h0000_0000_8000_0000;

  typedef struct packed {
    inst_t inst;
  } fetch_pkt_t;

  typedef struct packed {
    alu_op_t   alu_op;
    xlen_t     op_a;
    xlen_t     op_b;
    xlen_t     st_data;
    logic      is_load;
    logic      is_store;
    logic      is_branch;
    logic      br_ne;
    logic      is_putch;
    logic      reg_wr;
    reg_addr_t dest;
    xlen_t     br_off;
    xlen_t     imm;
  } issue_pkt_t;

  typedef struct packed {
    xlen_t     result;
    xlen_t     st_data;
    reg_addr_t dest;
    logic      is_load;
    logic      is_store;
    logic      is_putch;
    logic      reg_wr;
  } exec_pkt_t;

  typedef enum logic {F_IDLE, F_WAIT} fetch_state_e;
  typedef enum logic {M_IDLE, M_BUSY} mem_state_e;

endpackage

`default_nettype wire

// ==== design/core_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module core_top
  import core_pkg::*;
(
  input  wire        clock,
  input  wire        reset,

  // instruction fetch bus
  output logic       if_rw_valid,
  output xlen_t      if_rw_addr,
  input  wire        if_rw_ready,
  input  inst_t      if_r_data,

  // data bus
  output logic       mem_rw_valid,
  output logic       mem_rw_req,
  output xlen_t      mem_rw_addr,
  output xlen_t      mem_w_data,
  input  wire        mem_rw_ready,
  input  xlen_t      mem_r_data,

  // serial output
  output logic       uart_out_valid,
  output logic [7:0] uart_out_char
);

  logic      redirect;
  xlen_t     redirect_pc;
  logic      ex_dest_valid;
  reg_addr_t ex_dest;
  logic      mem_dest_valid;
  reg_addr_t mem_dest;
  logic      wr_ena;
  reg_addr_t wr_addr;
  xlen_t     wr_data;

  stage_link #(.payload_t(fetch_pkt_t)) if_id ();
  stage_link #(.payload_t(issue_pkt_t)) id_ex ();
  stage_link #(.payload_t(exec_pkt_t))  ex_mem ();
  reg_read_if                           rf_rd ();

  fetch_stage u_fetch (
    .clock       (clock),
    .reset       (reset),
    .if_rw_valid (if_rw_valid),
    .if_rw_addr  (if_rw_addr),
    .if_rw_ready (if_rw_ready),
    .if_r_data   (if_r_data),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .out_link    (if_id.up)
  );

  decode_stage u_decode (
    .clock          (clock),
    .reset          (reset),
    .in_link        (if_id.down),
    .out_link       (id_ex.up),
    .rf             (rf_rd.reader),
    .ex_dest_valid  (ex_dest_valid),
    .ex_dest        (ex_dest),
    .mem_dest_valid (mem_dest_valid),
    .mem_dest       (mem_dest),
    .redirect       (redirect)
  );

  reg_file u_reg_file (
    .clock   (clock),
    .reset   (reset),
    .rd      (rf_rd.file),
    .wr_ena  (wr_ena),
    .wr_addr (wr_addr),
    .wr_data (wr_data)
  );

  execute_stage u_execute (
    .clock         (clock),
    .reset         (reset),
    .in_link       (id_ex.down),
    .out_link      (ex_mem.up),
    .redirect      (redirect),
    .redirect_pc   (redirect_pc),
    .ex_dest_valid (ex_dest_valid),
    .ex_dest       (ex_dest)
  );

  memory_stage u_memory (
    .clock          (clock),
    .reset          (reset),
    .in_link        (ex_mem.down),
    .mem_rw_valid   (mem_rw_valid),
    .mem_rw_req     (mem_rw_req),
    .mem_rw_addr    (mem_rw_addr),
    .mem_w_data     (mem_w_data),
    .mem_rw_ready   (mem_rw_ready),
    .mem_r_data     (mem_r_data),
    .wr_ena         (wr_ena),
    .wr_addr        (wr_addr),
    .wr_data        (wr_data),
    .mem_dest_valid (mem_dest_valid),
    .mem_dest       (mem_dest),
    .uart_out_valid (uart_out_valid),
    .uart_out_char  (uart_out_char)
  );

endmodule

`default_nettype wire

// ==== design/decode_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module decode_stage
  import core_pkg::*;
(
  input  wire          clock,
  input  wire          reset,
  stage_link.down      in_link,
  stage_link.up        out_link,
  reg_read_if.reader   rf,
  input  wire          ex_dest_valid,
  input  reg_addr_t    ex_dest,
  input  wire          mem_dest_valid,
  input  reg_addr_t    mem_dest,
  input  wire          redirect
);

  logic       v;
  xlen_t      pc;
  inst_t      inst;
  issue_pkt_t pkt;
  logic       use_rs1;
  logic       use_rs2;
  logic       op_ok;
  logic       rs1_hit;
  logic       rs2_hit;
  logic       hazard;
  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  reg_addr_t  rd;
  xlen_t      imm_i;
  xlen_t      imm_s;
  xlen_t      imm_b;

  assign opcode = inst[6:0];
  assign rd     = inst[11:7];
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];
  assign imm_i  = {{52{inst[31]}}, inst[31:20]};
  assign imm_s  = {{52{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_b  = {{51{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};

  // putch reads a0 through the rs1 port
  assign rf.rs1 = (opcode == OPC_PUTCH) ? REG_A0 : inst[19:15];
  assign rf.rs2 = inst[24:20];

  always_comb begin
    pkt         = '0;
    use_rs1     = 1'b0;
    use_rs2     = 1'b0;
    op_ok       = 1'b1;
    pkt.alu_op  = ALU_ADD;
    pkt.op_a    = rf.rs1_data;
    pkt.op_b    = rf.rs2_data;
    pkt.st_data = rf.rs2_data;
    pkt.dest    = rd;
    pkt.imm     = imm_i;
    pkt.br_off  = imm_b;
    case (opcode)
      OPC_OP_IMM: begin
        // ADDI only
        op_ok      = (funct3 == 3'h0);
        use_rs1    = op_ok;
        pkt.op_b   = imm_i;
        pkt.reg_wr = op_ok && (rd != '0);
      end
      OPC_OP: begin
        case ({funct7, funct3})
          {7'h00, 3'h0}: pkt.alu_op = ALU_ADD;
          {7'h20, 3'h0}: pkt.alu_op = ALU_SUB;
          {7'h00, 3'h4}: pkt.alu_op = ALU_XOR;
          {7'h00, 3'h6}: pkt.alu_op = ALU_OR;
          {7'h00, 3'h7}: pkt.alu_op = ALU_AND;
          default:       op_ok = 1'b0;
        endcase
        use_rs1    = op_ok;
        use_rs2    = op_ok;
        pkt.reg_wr = op_ok && (rd != '0);
      end
      OPC_LOAD: begin
        op_ok       = (funct3 == 3'h3);
        use_rs1     = op_ok;
        pkt.is_load = op_ok;
        pkt.reg_wr  = op_ok && (rd != '0);
      end
      OPC_STORE: begin
        op_ok        = (funct3 == 3'h3);
        use_rs1      = op_ok;
        use_rs2      = op_ok;
        pkt.is_store = op_ok;
        pkt.imm      = imm_s;
      end
      OPC_BRANCH: begin
        op_ok         = (funct3 == 3'h0) || (funct3 == 3'h1);
        use_rs1       = op_ok;
        use_rs2       = op_ok;
        pkt.is_branch = op_ok;
        pkt.br_ne     = funct3[0];
      end
      OPC_PUTCH: begin
        use_rs1      = 1'b1;
        // a0 passes through the adder unchanged
        pkt.op_b     = '0;
        pkt.is_putch = 1'b1;
      end
      // anything else leaves as a no-op
      default: op_ok = 1'b0;
    endcase
  end

  // scoreboard against older writers where x0 never blocks
  assign rs1_hit = use_rs1 && (rf.rs1 != '0) &&
                   ((ex_dest_valid && ex_dest == rf.rs1) ||
                    (mem_dest_valid && mem_dest == rf.rs1));
  assign rs2_hit = use_rs2 && (rf.rs2 != '0) &&
                   ((ex_dest_valid && ex_dest == rf.rs2) ||
                    (mem_dest_valid && mem_dest == rf.rs2));
  assign hazard  = rs1_hit || rs2_hit;

  assign out_link.valid   = v && !hazard && !redirect;
  assign out_link.pc      = pc;
  assign out_link.payload = pkt;
  assign in_link.allowin  = !v || (out_link.valid && out_link.allowin);

  always_ff @(posedge clock) begin
    if (reset) begin
      v <= 1'b0;
    end else if (redirect) begin
      v <= 1'b0;
    end else if (in_link.allowin) begin
      v <= in_link.valid;
    end
  end

  always_ff @(posedge clock) begin
    if (in_link.allowin && in_link.valid) begin
      pc   <= in_link.pc;
      inst <= in_link.payload.inst;
    end
  end

endmodule

`default_nettype wire

// ==== design/execute_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module execute_stage
  import core_pkg::*;
(
  input  wire        clock,
  input  wire        reset,
  stage_link.down    in_link,
  stage_link.up      out_link,
  output logic       redirect,
  output xlen_t      redirect_pc,
  output logic       ex_dest_valid,
  output reg_addr_t  ex_dest
);

  logic       v;
  xlen_t      pc;
  issue_pkt_t pkt;
  xlen_t      alu_res;
  logic       taken;
  exec_pkt_t  out_pkt;

  assign in_link.allowin = !v || out_link.allowin;

  always_ff @(posedge clock) begin
    if (reset) begin
      v <= 1'b0;
    end else if (in_link.allowin) begin
      v <= in_link.valid;
    end
  end

  always_ff @(posedge clock) begin
    if (in_link.allowin && in_link.valid) begin
      pc  <= in_link.pc;
      pkt <= in_link.payload;
    end
  end

  always_comb begin
    case (pkt.alu_op)
      ALU_SUB: alu_res = pkt.op_a - pkt.op_b;
      ALU_AND: alu_res = pkt.op_a & pkt.op_b;
      ALU_OR:  alu_res = pkt.op_a | pkt.op_b;
      ALU_XOR: alu_res = pkt.op_a ^ pkt.op_b;
      default: alu_res = pkt.op_a + pkt.op_b;
    endcase
  end

  // beq when equal, bne when not
  assign taken = pkt.is_branch && ((pkt.op_a == pkt.op_b) != pkt.br_ne);

  // fires as the branch moves on to memory
  assign redirect    = v && taken && out_link.allowin;
  assign redirect_pc = pc + pkt.br_off;

  always_comb begin
    out_pkt          = '0;
    out_pkt.result   = (pkt.is_load || pkt.is_store) ? pkt.op_a + pkt.imm : alu_res;
    out_pkt.st_data  = pkt.st_data;
    out_pkt.dest     = pkt.dest;
    out_pkt.is_load  = pkt.is_load;
    out_pkt.is_store = pkt.is_store;
    out_pkt.is_putch = pkt.is_putch;
    out_pkt.reg_wr   = pkt.reg_wr && !pkt.is_branch;
  end

  assign out_link.valid   = v;
  assign out_link.pc      = pc;
  assign out_link.payload = out_pkt;

  assign ex_dest_valid = v && pkt.reg_wr;
  assign ex_dest       = pkt.dest;

  // decode holds back its item, so no second redirect follows
  a_redirect_pulse: assert property (@(posedge clock) disable iff (reset)
    redirect |=> !redirect);

endmodule

`default_nettype wire

// ==== design/fetch_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module fetch_stage
  import core_pkg::*;
(
  input  wire          clock,
  input  wire          reset,
  output logic         if_rw_valid,
  output xlen_t        if_rw_addr,
  input  wire          if_rw_ready,
  input  inst_t        if_r_data,
  input  wire          redirect,
  input  xlen_t        redirect_pc,
  stage_link.up        out_link
);

  fetch_state_e state;
  xlen_t        pc;
  logic         stale;
  xlen_t        stale_pc;
  logic         out_valid;
  xlen_t        out_pc;
  fetch_pkt_t   out_pkt;
  logic         fetch_fire;

  // request is held in F_WAIT until ready
  assign if_rw_valid = (state == F_WAIT);
  assign if_rw_addr  = pc;
  assign fetch_fire  = if_rw_valid && if_rw_ready;

  assign out_link.valid   = out_valid;
  assign out_link.pc      = out_pc;
  assign out_link.payload = out_pkt;

  always_ff @(posedge clock) begin
    if (reset) begin
      state     <= F_WAIT;
      pc        <= RESET_PC;
      stale     <= 1'b0;
      out_valid <= 1'b0;
    end else begin
      if ((out_valid && out_link.allowin) || redirect) begin
        out_valid <= 1'b0;
      end
      case (state)
        F_IDLE: begin
          if (redirect) begin
            pc    <= redirect_pc;
            state <= F_WAIT;
          end else if (!out_valid || out_link.allowin) begin
            // next request goes out right after the slot drains
            state <= F_WAIT;
          end
        end
        F_WAIT: begin
          if (fetch_fire) begin
            stale <= 1'b0;
            if (stale || redirect) begin
              // wrong-path response, refetch at the branch target
              pc <= redirect ? redirect_pc : stale_pc;
            end else begin
              out_valid <= 1'b1;
              pc        <= pc + 64'd4;
              state     <= F_IDLE;
            end
          end else if (redirect) begin
            stale <= 1'b1;
          end
        end
        default: state <= F_WAIT;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (state == F_WAIT && !fetch_fire && redirect) begin
      stale_pc <= redirect_pc;
    end
    if (fetch_fire) begin
      out_pc       <= pc;
      out_pkt.inst <= if_r_data;
    end
  end

  // pending request must not move before ready
  a_if_req_stable: assert property (@(posedge clock) disable iff (reset)
    if_rw_valid && !if_rw_ready |=> if_rw_valid && $stable(if_rw_addr));

endmodule

`default_nettype wire

// ==== design/memory_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module memory_stage
  import core_pkg::*;
(
  input  wire        clock,
  input  wire        reset,
  stage_link.down    in_link,
  output logic       mem_rw_valid,
  output logic       mem_rw_req,
  output xlen_t      mem_rw_addr,
  output xlen_t      mem_w_data,
  input  wire        mem_rw_ready,
  input  xlen_t      mem_r_data,
  output logic       wr_ena,
  output reg_addr_t  wr_addr,
  output xlen_t      wr_data,
  output logic       mem_dest_valid,
  output reg_addr_t  mem_dest,
  output logic       uart_out_valid,
  output logic [7:0] uart_out_char
);

  mem_state_e state;
  logic       v;
  exec_pkt_t  pkt;
  logic       is_mem;
  logic       done;

  assign is_mem = pkt.is_load || pkt.is_store;

  // alu and putch items retire at once, bus items on the handshake
  assign done = v && (!is_mem || (state == M_BUSY && mem_rw_ready));

  assign in_link.allowin = !v || done;

  always_ff @(posedge clock) begin
    if (reset) begin
      v     <= 1'b0;
      state <= M_IDLE;
    end else if (in_link.allowin) begin
      v <= in_link.valid;
      if (in_link.valid && (in_link.payload.is_load || in_link.payload.is_store)) begin
        state <= M_BUSY;
      end else begin
        state <= M_IDLE;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (in_link.allowin && in_link.valid) begin
      pkt <= in_link.payload;
    end
  end

  // data bus request
  assign mem_rw_valid = (state == M_BUSY);
  assign mem_rw_req   = pkt.is_store;
  assign mem_rw_addr  = pkt.result;
  assign mem_w_data   = pkt.st_data;

  // writeback
  assign wr_ena  = done && pkt.reg_wr;
  assign wr_addr = pkt.dest;
  assign wr_data = pkt.is_load ? mem_r_data : pkt.result;

  // the finishing write is bypassed by the register file
  assign mem_dest_valid = v && pkt.reg_wr && !done;
  assign mem_dest       = pkt.dest;

  assign uart_out_valid = done && pkt.is_putch;
  assign uart_out_char  = pkt.result[7:0];

  a_mem_req_held: assert property (@(posedge clock) disable iff (reset)
    mem_rw_valid && !mem_rw_ready |=> mem_rw_valid && $stable(mem_rw_addr));

endmodule

`default_nettype wire

// ==== design/reg_file.sv ====
`timescale 1ns/100ps
`default_nettype none

module reg_file
  import core_pkg::*;
(
  input  wire        clock,
  input  wire        reset,
  reg_read_if.file   rd,
  input  wire        wr_ena,
  input  reg_addr_t  wr_addr,
  input  xlen_t      wr_data
);

  // x0 has no storage
  xlen_t regs [1:31];

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_ena && wr_addr != '0) begin
      regs[wr_addr] <= wr_data;
    end
  end

  // write data bypasses into the same-cycle read
  always_comb begin
    if (rd.rs1 == '0) begin
      rd.rs1_data = '0;
    end else if (wr_ena && wr_addr == rd.rs1) begin
      rd.rs1_data = wr_data;
    end else begin
      rd.rs1_data = regs[rd.rs1];
    end
  end

  always_comb begin
    if (rd.rs2 == '0) begin
      rd.rs2_data = '0;
    end else if (wr_ena && wr_addr == rd.rs2) begin
      rd.rs2_data = wr_data;
    end else begin
      rd.rs2_data = regs[rd.rs2];
    end
  end

  // decode never flags a write to x0
  a_no_x0_write: assert property (@(posedge clock) disable iff (reset)
    wr_ena |-> wr_addr != '0);

endmodule

`default_nettype wire

// ==== design/reg_read_if.sv ====
`timescale 1ns/100ps
`default_nettype none

interface reg_read_if
  import core_pkg::*;
();

  reg_addr_t rs1;
  reg_addr_t rs2;
  xlen_t     rs1_data;
  xlen_t     rs2_data;

  modport reader (output rs1, rs2, input rs1_data, rs2_data);
  modport file (input rs1, rs2, output rs1_data, rs2_data);

endinterface

`default_nettype wire

// ==== design/stage_link.sv ====
`timescale 1ns/100ps
`default_nettype none

// one pipeline hop, item moves when valid and allowin are both high
interface stage_link
  import core_pkg::*;
#(
  parameter type payload_t = logic
) ();

  logic     valid;
  logic     allowin;
  xlen_t    pc;
  payload_t payload;

  modport up (output valid, pc, payload, input allowin);
  modport down (input valid, pc, payload, output allowin);

endinterface

`default_nettype wire

// ==== dv/core_model.sv ====
`timescale 1ns/100ps
`default_nettype none

module core_model
  import core_pkg::*;
();

  localparam int    PROG_LEN  = 128;
  localparam xlen_t PROG_BASE = 64'h0000_0000_8000_0000;
  localparam int    K_ADDI    = 0;
  localparam int    K_ALU     = 1;
  localparam int    K_LD      = 2;
  localparam int    K_SD      = 3;
  localparam int    K_BR      = 4;
  localparam int    K_PUTCH   = 5;
  localparam int    K_NOP     = 6;

  inst_t      prog    [0:PROG_LEN-1];
  int         kind    [0:PROG_LEN-1];
  logic [4:0] f_rd    [0:PROG_LEN-1];
  logic [4:0] f_rs1   [0:PROG_LEN-1];
  logic [4:0] f_rs2   [0:PROG_LEN-1];
  int         f_op    [0:PROG_LEN-1];
  int         f_tgt   [0:PROG_LEN-1];
  xlen_t      f_imm   [0:PROG_LEN-1];
  logic       skipped [0:PROG_LEN-1];
  logic [7:0] exp_bytes [$];
  // address then data for each expected store
  xlen_t      exp_stores [$];
  xlen_t      bus_mem [0:31];
  logic       bus_wr  [0:31];

  function automatic int unsigned pick(inout integer seed, input int unsigned n);
    pick = $unsigned($random(seed)) % n;
  endfunction

  // unwritten data words read back as their own address
  function automatic xlen_t fill_word(input xlen_t addr);
    return addr;
  endfunction

  function automatic inst_t fetch_word(input xlen_t addr);
    xlen_t idx;
    idx = (addr - PROG_BASE) >> 2;
    if (addr >= PROG_BASE && idx < PROG_LEN && addr[1:0] == 2'b00) begin
      return prog[idx];
    end
    // addi x0, x0, 0 outside the program
    return 32'h0000_0013;
  endfunction

  function automatic xlen_t end_addr();
    return PROG_BASE + 4 * (PROG_LEN - 1);
  endfunction

  function automatic logic is_skipped(input xlen_t addr);
    xlen_t idx;
    idx = (addr - PROG_BASE) >> 2;
    if (addr >= PROG_BASE && idx < PROG_LEN) begin
      return skipped[idx];
    end
    return 1'b0;
  endfunction

  function automatic xlen_t bus_read(input xlen_t addr);
    if (addr < 256 && bus_wr[addr[7:3]]) begin
      return bus_mem[addr[7:3]];
    end
    return fill_word(addr);
  endfunction

  task automatic bus_write(input xlen_t addr, input xlen_t data);
    if (addr < 256) begin
      bus_mem[addr[7:3]] = data;
      bus_wr[addr[7:3]]  = 1'b1;
    end
  endtask

  task automatic bus_clear();
    for (int i = 0; i < 32; i++) begin
      bus_wr[i] = 1'b0;
    end
  endtask

  task automatic gen_program(inout integer seed);
    int unsigned r;
    int          t;
    logic [11:0] imm12;
    logic [12:0] off;
    logic [6:0]  f7;
    logic [2:0]  f3;
    inst_t       junk;
    for (int i = 0; i < PROG_LEN - 1; i++) begin
      r        = pick(seed, 100);
      f_rd[i]  = 1 + pick(seed, 15);
      // a0 gets written often so putch has fresh values
      if (pick(seed, 3) == 0) begin
        f_rd[i] = 5'd10;
      end
      f_rs1[i] = 1 + pick(seed, 15);
      f_rs2[i] = 1 + pick(seed, 15);
      f_op[i]  = pick(seed, 5);
      f_tgt[i] = i + 1;
      f_imm[i] = '0;
      if (r < 20) begin
        kind[i]  = K_ADDI;
        imm12    = $random(seed);
        f_imm[i] = {{52{imm12[11]}}, imm12};
        prog[i]  = {imm12, f_rs1[i], 3'h0, f_rd[i], 7'h13};
      end else if (r < 40) begin
        kind[i] = K_ALU;
        case (f_op[i])
          1:       {f7, f3} = {7'h20, 3'h0};
          2:       {f7, f3} = {7'h00, 3'h7};
          3:       {f7, f3} = {7'h00, 3'h6};
          4:       {f7, f3} = {7'h00, 3'h4};
          default: {f7, f3} = {7'h00, 3'h0};
        endcase
        prog[i] = {f7, f_rs2[i], f_rs1[i], f3, f_rd[i], 7'h33};
      end else if (r < 50) begin
        kind[i]  = K_LD;
        f_imm[i] = pick(seed, 32) * 8;
        prog[i]  = {f_imm[i][11:0], 5'd0, 3'h3, f_rd[i], 7'h03};
      end else if (r < 60) begin
        kind[i]  = K_SD;
        f_imm[i] = pick(seed, 32) * 8;
        prog[i]  = {f_imm[i][11:5], f_rs2[i], 5'd0, 3'h3, f_imm[i][4:0], 7'h23};
      end else if (r < 70) begin
        kind[i] = K_BR;
        t       = i + 1 + pick(seed, 10);
        if (t > PROG_LEN - 1) begin
          t = PROG_LEN - 1;
        end
        f_tgt[i] = t;
        f_op[i]  = pick(seed, 2);
        f3       = (f_op[i] == 1) ? 3'h1 : 3'h0;
        off      = (t - i) * 4;
        prog[i]  = {off[12], off[10:5], f_rs2[i], f_rs1[i], f3, off[4:1], off[11], 7'h63};
      end else if (r < 92) begin
        kind[i] = K_PUTCH;
        // random filler above the putch opcode
        junk    = $random(seed);
        prog[i] = {junk[31:7], 7'h7b};
      end else begin
        // unsupported opcode retires as a no-op
        kind[i] = K_NOP;
        junk    = $random(seed);
        prog[i] = {junk[31:7], 7'h0b};
      end
    end
    // beq x0, x0, 0
    kind[PROG_LEN-1] = K_BR;
    prog[PROG_LEN-1] = 32'h0000_0063;
  endtask

  task automatic run_model();
    xlen_t x   [0:31];
    xlen_t mem [0:31];
    logic  wr  [0:31];
    int    i;
    int    steps;
    logic  taken;
    xlen_t a;
    xlen_t b;
    for (int k = 0; k < 32; k++) begin
      x[k]  = '0;
      wr[k] = 1'b0;
    end
    for (int k = 0; k < PROG_LEN; k++) begin
      skipped[k] = 1'b0;
    end
    exp_bytes.delete();
    exp_stores.delete();
    i     = 0;
    steps = 0;
    while (i != PROG_LEN - 1 && steps < 2 * PROG_LEN) begin
      steps++;
      taken = 1'b0;
      a     = x[f_rs1[i]];
      b     = x[f_rs2[i]];
      case (kind[i])
        K_ADDI: x[f_rd[i]] = a + f_imm[i];
        K_ALU: begin
          case (f_op[i])
            1:       x[f_rd[i]] = a - b;
            2:       x[f_rd[i]] = a & b;
            3:       x[f_rd[i]] = a | b;
            4:       x[f_rd[i]] = a ^ b;
            default: x[f_rd[i]] = a + b;
          endcase
        end
        K_LD: begin
          x[f_rd[i]] = wr[f_imm[i][7:3]] ? mem[f_imm[i][7:3]] : fill_word(f_imm[i]);
        end
        K_SD: begin
          mem[f_imm[i][7:3]] = b;
          wr[f_imm[i][7:3]]  = 1'b1;
          exp_stores.push_back(f_imm[i]);
          exp_stores.push_back(b);
        end
        K_PUTCH: exp_bytes.push_back(x[10][7:0]);
        K_BR:    taken = (a == b) != (f_op[i] == 1);
        default: ;
      endcase
      if (taken) begin
        // two slots after a branch may be fetched before it resolves
        for (int j = i + 3; j < f_tgt[i]; j++) begin
          skipped[j] = 1'b1;
        end
        i = f_tgt[i];
      end else begin
        i++;
      end
    end
  endtask

endmodule

`default_nettype wire

// ==== dv/core_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module core_tb
  import core_pkg::*;
();

  localparam xlen_t BOOT_PC   = 64'h0000_0000_8000_0000;
  localparam int    RUN_LIMIT = 20000;

  logic        clock;
  logic        reset;
  logic        if_rw_valid;
  xlen_t       if_rw_addr;
  logic        if_rw_ready;
  inst_t       if_r_data;
  logic        mem_rw_valid;
  logic        mem_rw_req;
  xlen_t       mem_rw_addr;
  xlen_t       mem_w_data;
  logic        mem_rw_ready;
  xlen_t       mem_r_data;
  logic        uart_out_valid;
  logic [7:0]  uart_out_char;

  integer      seed;
  bit          slow_bus;
  int          if_delay;
  int          mem_delay;
  bit          if_fired;
  bit          mem_fired;
  int          byte_idx;
  int          store_idx;
  bit          fetch_end;
  int          err_byte;
  int          err_store;
  int          err_fetch;
  int          tests_run;
  int          tests_failed;
  bit          timed_out;
  logic [7:0]  cur_bytes [$];
  logic [7:0]  first_bytes [$];
  xlen_t       cur_stores [$];
  xlen_t       first_stores [$];

  core_model model ();

  core_top uut (
    .clock          (clock),
    .reset          (reset),
    .if_rw_valid    (if_rw_valid),
    .if_rw_addr     (if_rw_addr),
    .if_rw_ready    (if_rw_ready),
    .if_r_data      (if_r_data),
    .mem_rw_valid   (mem_rw_valid),
    .mem_rw_req     (mem_rw_req),
    .mem_rw_addr    (mem_rw_addr),
    .mem_w_data     (mem_w_data),
    .mem_rw_ready   (mem_rw_ready),
    .mem_r_data     (mem_r_data),
    .uart_out_valid (uart_out_valid),
    .uart_out_char  (uart_out_char)
  );

  always #20 clock = ~clock;

  function automatic int next_delay();
    if (!slow_bus) begin
      return 0;
    end
    return $unsigned($random(seed)) % 4;
  endfunction

  // bus responders drive inputs on the falling edge
  always @(negedge clock) begin
    if (if_fired || reset) begin
      if_fired = 1'b0;
      if_delay = next_delay();
    end
    if (mem_fired || reset) begin
      mem_fired = 1'b0;
      mem_delay = next_delay();
    end
    if (!reset && if_rw_valid && if_delay == 0) begin
      if_rw_ready <= 1'b1;
      if_r_data   <= model.fetch_word(if_rw_addr);
    end else begin
      if_rw_ready <= 1'b0;
      if (!reset && if_rw_valid) if_delay--;
    end
    if (!reset && mem_rw_valid && mem_delay == 0) begin
      mem_rw_ready <= 1'b1;
      mem_r_data   <= model.bus_read(mem_rw_addr);
    end else begin
      mem_rw_ready <= 1'b0;
      if (!reset && mem_rw_valid) mem_delay--;
    end
  end

  // monitors on the rising edge
  always @(posedge clock) begin
    if (!reset) begin
      if (if_rw_valid && if_rw_ready) begin
        if_fired = 1'b1;
        if (if_rw_addr == model.end_addr()) begin
          fetch_end = 1'b1;
        end else if (!fetch_end && model.is_skipped(if_rw_addr)) begin
          $display("Fail at %0t: fetch of skipped address %h", $time, if_rw_addr);
          err_fetch++;
        end
      end
      if (mem_rw_valid && mem_rw_ready) begin
        mem_fired = 1'b1;
        if (mem_rw_req) begin
          if (2 * store_idx + 1 >= model.exp_stores.size()) begin
            $display("Fail at %0t: unexpected store to %h", $time, mem_rw_addr);
            err_store++;
          end else if (mem_rw_addr !== model.exp_stores[2 * store_idx] ||
                       mem_w_data !== model.exp_stores[2 * store_idx + 1]) begin
            $display("Fail at %0t: store %0d wrote %h to %h, expected %h to %h", $time,
                     store_idx, mem_w_data, mem_rw_addr, model.exp_stores[2 * store_idx + 1],
                     model.exp_stores[2 * store_idx]);
            err_store++;
          end
          model.bus_write(mem_rw_addr, mem_w_data);
          cur_stores.push_back(mem_rw_addr);
          cur_stores.push_back(mem_w_data);
          store_idx++;
        end
      end
      if (uart_out_valid) begin
        if (byte_idx >= model.exp_bytes.size()) begin
          $display("Fail at %0t: unexpected serial byte %h", $time, uart_out_char);
          err_byte++;
        end else if (uart_out_char !== model.exp_bytes[byte_idx]) begin
          $display("Fail at %0t: serial byte %0d is %h, expected %h", $time, byte_idx,
                   uart_out_char, model.exp_bytes[byte_idx]);
          err_byte++;
        end
        cur_bytes.push_back(uart_out_char);
        byte_idx++;
      end
    end
  end

  task automatic report(input string name, input bit ok);
    tests_run++;
    if (!ok) tests_failed++;
    $display("%s: %s", name, ok ? "pass" : "fail");
  endtask

  task automatic apply_reset(input int pass_no);
    bit ok;
    ok = 1'b1;
    @(negedge clock);
    reset <= 1'b1;
    repeat (16) begin
      @(negedge clock);
      if (uart_out_valid !== 1'b0 || mem_rw_valid !== 1'b0) begin
        $display("Fail at %0t: bus or serial valid high during reset", $time);
        ok = 1'b0;
      end
    end
    reset <= 1'b0;
    @(negedge clock);
    if (uart_out_valid !== 1'b0 || mem_rw_valid !== 1'b0) begin
      $display("Fail at %0t: bus or serial valid high after reset", $time);
      ok = 1'b0;
    end
    if (if_rw_valid !== 1'b1 || if_rw_addr !== BOOT_PC) begin
      $display("Fail at %0t: first fetch at %h, expected %h", $time, if_rw_addr, BOOT_PC);
      ok = 1'b0;
    end
    report($sformatf("pass %0d reset and first fetch", pass_no), ok);
  endtask

  task automatic run_pass(input int pass_no);
    int cycles;
    bit same;
    slow_bus  = (pass_no == 2);
    byte_idx  = 0;
    store_idx = 0;
    err_byte  = 0;
    err_store = 0;
    err_fetch = 0;
    cur_bytes.delete();
    cur_stores.delete();
    model.bus_clear();
    apply_reset(pass_no);
    // the previous pass may still have looped through the end address
    fetch_end = 1'b0;
    cycles = 0;
    while (!(fetch_end && byte_idx == model.exp_bytes.size() &&
             2 * store_idx == model.exp_stores.size()) && cycles < RUN_LIMIT) begin
      @(negedge clock);
      cycles++;
    end
    if (cycles >= RUN_LIMIT) begin
      $display("pass %0d: program did not finish within %0d cycles", pass_no, RUN_LIMIT);
      tests_failed++;
      timed_out = 1'b1;
      return;
    end
    // a quiet spell to catch extra bytes or stores
    repeat (60) @(negedge clock);
    report($sformatf("pass %0d serial bytes (%0d)", pass_no, byte_idx),
           err_byte == 0 && byte_idx == model.exp_bytes.size());
    report($sformatf("pass %0d stores (%0d)", pass_no, store_idx),
           err_store == 0 && 2 * store_idx == model.exp_stores.size());
    report($sformatf("pass %0d fetch path", pass_no), err_fetch == 0 && fetch_end);
    if (pass_no == 1) begin
      first_bytes  = cur_bytes;
      first_stores = cur_stores;
    end else begin
      same = (cur_bytes.size() == first_bytes.size()) &&
             (cur_stores.size() == first_stores.size());
      for (int i = 0; same && i < cur_bytes.size(); i++) begin
        if (cur_bytes[i] !== first_bytes[i]) same = 1'b0;
      end
      for (int i = 0; same && i < cur_stores.size(); i++) begin
        if (cur_stores[i] !== first_stores[i]) same = 1'b0;
      end
      if (!same) begin
        $display("pass two byte or store sequence differs from pass one");
      end
      report("pass 2 matches pass 1", same);
    end
  endtask

  initial begin
    clock        = 1'b0;
    reset        = 1'b1;
    if_rw_ready  = 1'b0;
    if_r_data    = '0;
    mem_rw_ready = 1'b0;
    mem_r_data   = '0;
    seed         = 32'hac2f_9f9f;
    slow_bus     = 1'b0;
    if_fired     = 1'b0;
    mem_fired    = 1'b0;
    if_delay     = 0;
    mem_delay    = 0;
    tests_run    = 0;
    tests_failed = 0;
    timed_out    = 1'b0;
    model.gen_program(seed);
    model.run_model();
    $display("program: %0d serial bytes, %0d stores expected",
             model.exp_bytes.size(), model.exp_stores.size() / 2);
    run_pass(1);
    if (!timed_out) begin
      run_pass(2);
    end
    $display("tests run %0d, passed %0d, failed %0d", tests_run,
             tests_run - tests_failed, tests_failed);
    if (tests_failed == 0 && !timed_out) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== flist.f ====
design/core_pkg.sv
design/stage_link.sv
design/reg_read_if.sv
design/fetch_stage.sv
design/decode_stage.sv
design/reg_file.sv
design/execute_stage.sv
design/memory_stage.sv
design/core_top.sv
dv/core_model.sv
dv/core_tb.sv
